//--- hw/memPkg.sv
package memPkg;

    // bytes in one word
    localparam int maxBytes = 4;

    typedef logic [31:0] addrT;

    typedef logic [8*maxBytes-1:0] wordT;

    typedef logic [7:0] byteT;

    // lane select within a word
    typedef logic [$clog2(maxBytes)-1:0] byteIdxT;

    // each value is its own byte count
    typedef enum logic [2:0] {
        len1 = 3'd1,
        len2 = 3'd2,
        len4 = 3'd4
    } lenT;

endpackage

//--- hw/clientIf.sv
interface clientIf;
    import memPkg::*;

    logic req;
    logic ack;
    addrT addr;
    lenT  len;
    logic isWrite;
    wordT wdata;
    wordT rdata;

    modport client (
        output req,
        output addr,
        output len,
        output isWrite,
        output wdata,
        input  ack,
        input  rdata
    );

    modport controller (
        input  req,
        input  addr,
        input  len,
        input  isWrite,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

//--- hw/seqIf.sv
interface seqIf;
    import memPkg::*;

    logic start;
    addrT addr;
    lenT  len;
    logic isWrite;
    wordT wdata;
    logic done;

    modport ctrl (
        output start,
        output addr,
        output len,
        output isWrite,
        output wdata,
        input  done
    );

    modport seq (
        input  start,
        input  addr,
        input  len,
        input  isWrite,
        input  wdata,
        output done
    );

    // assembler only needs to know when a transfer begins
    modport mon (
        input start
    );

endinterface

//--- hw/memArbiter.sv
module memArbiter (
    input  logic         clk,
    input  logic         rst,
    clientIf.controller  fetchPort,
    clientIf.controller  dataPort,
    seqIf.ctrl           seqCmd,
    input  memPkg::wordT i_word
);
    import memPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stBusy,
        stAcking
    } stateT;

    stateT state;
    logic  grantData;
    logic  startReg;
    logic  grantedReq;
    wordT  fetchRdata;
    wordT  dataRdata;

    assign grantedReq = grantData ? dataPort.req : fetchPort.req;

    // granted client holds its fields stable until ack
    assign seqCmd.start   = startReg;
    assign seqCmd.addr    = grantData ? dataPort.addr : fetchPort.addr;
    assign seqCmd.len     = grantData ? dataPort.len : fetchPort.len;
    assign seqCmd.isWrite = grantData ? dataPort.isWrite : fetchPort.isWrite;
    assign seqCmd.wdata   = grantData ? dataPort.wdata : fetchPort.wdata;

    assign fetchPort.ack   = (state == stAcking) && !grantData;
    assign dataPort.ack    = (state == stAcking) && grantData;
    assign fetchPort.rdata = fetchRdata;
    assign dataPort.rdata  = dataRdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            grantData <= 1'b0;
            startReg  <= 1'b0;
        end else begin
            startReg <= 1'b0;
            case (state)
                stIdle: begin
                    // data side wins a tie
                    if (dataPort.req) begin
                        grantData <= 1'b1;
                        startReg  <= 1'b1;
                        state     <= stBusy;
                    end else if (fetchPort.req) begin
                        grantData <= 1'b0;
                        startReg  <= 1'b1;
                        state     <= stBusy;
                    end
                end
                stBusy: begin
                    if (seqCmd.done) begin
                        state <= stAcking;
                    end
                end
                stAcking: begin
                    // stay here until the client lets go of req
                    if (!grantedReq) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // result capture, held through the ack phase
    always_ff @(posedge clk) begin
        if (state == stBusy && seqCmd.done) begin
            if (grantData) begin
                dataRdata <= i_word;
            end else begin
                fetchRdata <= i_word;
            end
        end
    end

endmodule

//--- hw/byteSequencer.sv
module byteSequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_ioFull,
    seqIf.seq               seqCmd,
    output memPkg::addrT    o_memAddr,
    output logic            o_memWe,
    output memPkg::byteT    o_memWdata,
    output logic            o_byteValid,
    output memPkg::byteIdxT o_byteIdx
);
    import memPkg::*;

    logic    active;
    logic    isWrite;
    byteIdxT cnt;
    addrT    baseAddr;
    lenT     lenReg;
    wordT    wdataReg;
    addrT    heldAddr;
    logic    pendValid;
    byteIdxT pendIdx;
    byteIdxT lastIdx;
    logic    atLast;

    assign lastIdx = byteIdxT'(lenReg - 1);
    assign atLast  = (cnt == lastIdx);

    // a stall re-presents the previous address, so the RAM output
    // after the stall still belongs to the pending read byte
    assign o_memAddr = i_ioFull ? heldAddr : baseAddr + addrT'(cnt);

    assign o_memWe     = active && isWrite && !i_ioFull;
    assign o_memWdata  = wdataReg[8*cnt +: 8];
    assign o_byteValid = pendValid && !i_ioFull;
    assign o_byteIdx   = pendIdx;

    assign seqCmd.done = !i_ioFull &&
                         ((active && isWrite && atLast) ||
                          (pendValid && pendIdx == lastIdx));

    always_ff @(posedge clk) begin
        heldAddr <= o_memAddr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            pendValid <= 1'b0;
        end else if (seqCmd.start) begin
            active    <= 1'b1;
            pendValid <= 1'b0;
        end else if (!i_ioFull) begin
            // read data comes back one cycle after its address
            pendValid <= active && !isWrite;
            if (active && atLast) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seqCmd.start) begin
            baseAddr <= seqCmd.addr;
            lenReg   <= seqCmd.len;
            isWrite  <= seqCmd.isWrite;
            wdataReg <= seqCmd.wdata;
            cnt      <= '0;
        end else if (!i_ioFull && active) begin
            pendIdx <= cnt;
            if (!atLast) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/wordAssembler.sv
module wordAssembler (
    input  logic            clk,
    input  logic            rst,
    seqIf.mon               seqMon,
    input  logic            i_byteValid,
    input  memPkg::byteIdxT i_byteIdx,
    input  memPkg::byteT    i_memRdata,
    output memPkg::wordT    o_word
);
    import memPkg::*;

    wordT wordReg;

    // lanes never written stay zero, which zero-extends short loads
    always_ff @(posedge clk) begin
        if (rst) begin
            wordReg <= '0;
        end else if (seqMon.start) begin
            wordReg <= '0;
        end else if (i_byteValid) begin
            wordReg[8*i_byteIdx +: 8] <= i_memRdata;
        end
    end

    // merge the incoming byte so the last one is visible together with done
    always_comb begin
        o_word = wordReg;
        if (i_byteValid) begin
            o_word[8*i_byteIdx +: 8] = i_memRdata;
        end
    end

endmodule

//--- hw/memCtrlTop.sv
module memCtrlTop (
    input  logic         clk,
    input  logic         rst,
    input  logic         i_ioFull,

    // byte RAM
    input  memPkg::byteT i_memRdata,
    output memPkg::addrT o_memAddr,
    output logic         o_memWe,
    output memPkg::byteT o_memWdata,

    // instruction fetch
    input  logic         i_fetchReq,
    input  memPkg::addrT i_fetchAddr,
    output logic         o_fetchAck,
    output memPkg::wordT o_fetchInst,

    // load/store
    input  logic         i_dataReq,
    input  logic         i_dataWrite,
    input  memPkg::lenT  i_dataLen,
    input  memPkg::addrT i_dataAddr,
    input  memPkg::wordT i_dataWdata,
    output logic         o_dataAck,
    output memPkg::wordT o_dataRdata
);
    import memPkg::*;

    clientIf fetchIf ();
    clientIf dataIf ();
    seqIf    seqBus ();

    logic    byteValid;
    byteIdxT byteIdx;
    wordT    word;

    // fetch is always a full-word read
    assign fetchIf.req     = i_fetchReq;
    assign fetchIf.addr    = i_fetchAddr;
    assign fetchIf.len     = len4;
    assign fetchIf.isWrite = 1'b0;
    assign fetchIf.wdata   = '0;
    assign o_fetchAck      = fetchIf.ack;
    assign o_fetchInst     = fetchIf.rdata;

    assign dataIf.req     = i_dataReq;
    assign dataIf.addr    = i_dataAddr;
    assign dataIf.len     = i_dataLen;
    assign dataIf.isWrite = i_dataWrite;
    assign dataIf.wdata   = i_dataWdata;
    assign o_dataAck      = dataIf.ack;
    assign o_dataRdata    = dataIf.rdata;

    memArbiter memArbiter_inst (
        .clk       (clk),
        .rst       (rst),
        .fetchPort (fetchIf.controller),
        .dataPort  (dataIf.controller),
        .seqCmd    (seqBus.ctrl),
        .i_word    (word)
    );

    byteSequencer byteSequencer_inst (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (i_ioFull),
        .seqCmd      (seqBus.seq),
        .o_memAddr   (o_memAddr),
        .o_memWe     (o_memWe),
        .o_memWdata  (o_memWdata),
        .o_byteValid (byteValid),
        .o_byteIdx   (byteIdx)
    );

    wordAssembler wordAssembler_inst (
        .clk         (clk),
        .rst         (rst),
        .seqMon      (seqBus.mon),
        .i_byteValid (byteValid),
        .i_byteIdx   (byteIdx),
        .i_memRdata  (i_memRdata),
        .o_word      (word)
    );

endmodule

//--- test/ramModel.sv
module ramModel (
    input  logic         clk,
    input  memPkg::addrT i_addr,
    input  logic         i_we,
    input  memPkg::byteT i_wdata,
    output memPkg::byteT o_rdata
);
    import memPkg::*;

    // 4 KiB with the upper address bits ignored
    byteT mem [0:4095];

    always @(posedge clk) begin
        if (i_we) begin
            mem[i_addr[11:0]] <= i_wdata;
        end
    end

    // read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr[11:0]];
    end

endmodule

//--- test/memCtrlTb.sv
module memCtrlTb;
    import memPkg::*;

    logic clk = 1'b0;
    logic rst;
    logic ioFull;
    logic stallOn;
    byteT memRdata;
    addrT memAddr;
    logic memWe;
    byteT memWdata;
    logic fetchReq;
    addrT fetchAddr;
    logic fetchAck;
    wordT fetchInst;
    logic dataReq;
    logic dataWrite;
    lenT  dataLen;
    addrT dataAddr;
    wordT dataWdata;
    logic dataAck;
    wordT dataRdata;

    int    cycleNo = 0;
    logic  prevFetchAck = 1'b0;
    logic  prevDataAck = 1'b0;
    byteT  shadow [0:4095];
    string nameQ [$];
    wordT  expQ [$];
    wordT  actQ [$];

    memCtrlTop memCtrlTop_inst (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (ioFull),
        .i_memRdata  (memRdata),
        .o_memAddr   (memAddr),
        .o_memWe     (memWe),
        .o_memWdata  (memWdata),
        .i_fetchReq  (fetchReq),
        .i_fetchAddr (fetchAddr),
        .o_fetchAck  (fetchAck),
        .o_fetchInst (fetchInst),
        .i_dataReq   (dataReq),
        .i_dataWrite (dataWrite),
        .i_dataLen   (dataLen),
        .i_dataAddr  (dataAddr),
        .i_dataWdata (dataWdata),
        .o_dataAck   (dataAck),
        .o_dataRdata (dataRdata)
    );

    ramModel ramModel_inst (
        .clk     (clk),
        .i_addr  (memAddr),
        .i_we    (memWe),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleNo <= cycleNo + 1;
    end

    // random stall pulses while enabled
    task automatic driveStalls();
        forever begin
            @(negedge clk);
            ioFull <= stallOn && ($urandom % 3 == 0);
        end
    endtask

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT exp, input wordT act);
        if (act !== exp) begin
            stopOnError($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stopOnError($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // little-endian bytes from the shadow with lanes past the length zero
    function automatic wordT expectedRead(input addrT addr, input lenT len);
        wordT w;
        w = '0;
        for (int k = 0; k < int'(len); k++) begin
            w[8*k +: 8] = shadow[(addr + k) & 32'hfff];
        end
        return w;
    endfunction

    function automatic void applyStore(input addrT addr, input lenT len, input wordT wdata);
        for (int k = 0; k < int'(len); k++) begin
            shadow[(addr + k) & 32'hfff] = wdata[8*k +: 8];
        end
    endfunction

    function automatic addrT randAddr();
        return addrT'(4 + ($urandom % 4080));
    endfunction

    function automatic lenT randLen();
        case ($urandom % 3)
            0: return len1;
            1: return len2;
            default: return len4;
        endcase
    endfunction

    task automatic waitAck(input bit isData, input logic level, input string name);
        int n;
        n = 0;
        while ((isData ? dataAck : fetchAck) !== level && n < 200) begin
            n++;
            @(negedge clk);
        end
        if ((isData ? dataAck : fetchAck) !== level) begin
            stopOnError($sformatf("timeout: %s, %s ack did not go to %0b in 200 cycles",
                                  name, isData ? "data" : "fetch", level));
        end
    endtask

    // one full four-phase transfer on either client
    task automatic runAccess(input bit isData, input string name, input logic write,
                             input lenT len, input addrT addr, input wordT wdata,
                             output int ackAt);
        wordT got;
        if (isData) begin
            dataAddr  <= addr;
            dataLen   <= len;
            dataWrite <= write;
            dataWdata <= wdata;
            dataReq   <= 1'b1;
        end else begin
            fetchAddr <= addr;
            fetchReq  <= 1'b1;
        end
        @(negedge clk);
        waitAck(isData, 1'b1, name);
        ackAt = cycleNo;
        got = isData ? dataRdata : fetchInst;
        if (write) begin
            applyStore(addr, len, wdata);
        end else begin
            nameQ.push_back(name);
            expQ.push_back(expectedRead(addr, len));
            actQ.push_back(got);
        end
        if (isData) begin
            dataReq <= 1'b0;
        end else begin
            fetchReq <= 1'b0;
        end
        @(negedge clk);
        waitAck(isData, 1'b0, name);
    endtask

    // compares queued results and watches the stall rules every cycle
    always @(negedge clk) begin
        if (!rst) begin
            while (nameQ.size() > 0) begin
                checkWord(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
            end
            if (ioFull) begin
                checkFlag("write during stall", 1'b0, memWe);
                checkFlag("ack after stall", 1'b0,
                          (dataAck && !prevDataAck) || (fetchAck && !prevFetchAck));
            end
            prevDataAck  = dataAck;
            prevFetchAck = fetchAck;
        end
    end

    initial begin
        addrT a;
        addrT b;
        lenT  l;
        int   at;
        int   fetchAt;
        int   dataAt;
        void'($urandom(32'h7ffd_42e4));
        rst       = 1'b1;
        ioFull    = 1'b0;
        stallOn   = 1'b0;
        fetchReq  = 1'b0;
        fetchAddr = '0;
        dataReq   = 1'b0;
        dataWrite = 1'b0;
        dataLen   = len4;
        dataAddr  = '0;
        dataWdata = '0;
        fork
            driveStalls();
        join_none
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = byteT'($urandom);
            ramModel_inst.mem[i] = shadow[i];
        end
        repeat (5) @(negedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkFlag("idle fetch ack", 1'b0, fetchAck);
        checkFlag("idle data ack", 1'b0, dataAck);
        checkFlag("idle write enable", 1'b0, memWe);

        repeat (20) runAccess(1'b0, "fetch", 1'b0, len4, randAddr(), '0, at);
        repeat (30) runAccess(1'b1, "load", 1'b0, randLen(), randAddr(), '0, at);

        repeat (15) begin
            a = randAddr();
            l = randLen();
            runAccess(1'b1, "store", 1'b1, l, a, wordT'($urandom), at);
            // neighbors on both sides must be untouched
            for (int k = 0; k < 5; k++) begin
                runAccess(1'b1, "load near store", 1'b0, len4, a - 2 + k, '0, at);
            end
            runAccess(1'b1, "short load after store", 1'b0, len1, a + l, '0, at);
        end

        repeat (10) begin
            a = randAddr();
            b = randAddr();
            fork
                runAccess(1'b0, "tie fetch", 1'b0, len4, a, '0, fetchAt);
                runAccess(1'b1, "tie load", 1'b0, randLen(), b, '0, dataAt);
            join
            checkFlag("data wins tie", 1'b1, dataAt < fetchAt);
        end

        stallOn <= 1'b1;
        repeat (25) begin
            a = randAddr();
            l = randLen();
            runAccess(1'b1, "stalled store", 1'b1, l, a, wordT'($urandom), at);
            runAccess(1'b1, "stalled load", 1'b0, randLen(), a - 1, '0, at);
            runAccess(1'b0, "stalled fetch", 1'b0, len4, a, '0, at);
        end
        stallOn <= 1'b0;

        // let the comparing process drain its queue
        repeat (3) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- filelist.f
hw/memPkg.sv
hw/clientIf.sv
hw/seqIf.sv
hw/memArbiter.sv
hw/byteSequencer.sv
hw/wordAssembler.sv
hw/memCtrlTop.sv
test/ramModel.sv
test/memCtrlTb.sv

//--- Bender.yml
package:
  name: memCtrl

sources:
  - files:
      - hw/memPkg.sv
      - hw/clientIf.sv
      - hw/seqIf.sv
      - hw/memArbiter.sv
      - hw/byteSequencer.sv
      - hw/wordAssembler.sv
      - hw/memCtrlTop.sv
  - target: test
    files:
      - test/ramModel.sv
      - test/memCtrlTb.sv
